// File: src/rv32_defs.svh
`ifndef RV32_DEFS_SVH
`define RV32_DEFS_SVH

// ========================================
// core geometry
// ========================================

// register and data width
`define XPR_LEN 32

// barrel depth, must stay at 5 or more so a hart never overlaps itself
`define RV_NUM_HARTS 8
`define HART_W 3

// every hart starts here
`define RESET_ADDRESS 32'h0000_0000

`define REG_ADDR_W 5

// ========================================
// memory geometry (word addresses)
// ========================================

`define IMEM_ADDR_W 10
`define DMEM_ADDR_W 10

`endif

// File: src/rv32_pkg.sv
`include "rv32_defs.svh"

package rv32_pkg;

    // ========================================
    // basic types
    // ========================================

    typedef logic [`XPR_LEN-1:0] rv32_data_t;
    typedef logic [`HART_W-1:0] rv32_hart_t;
    typedef logic [`REG_ADDR_W-1:0] rv32_reg_addr_t;
    typedef logic [`IMEM_ADDR_W-1:0] rv32_imem_addr_t;
    typedef logic [`DMEM_ADDR_W-1:0] rv32_dmem_addr_t;
    typedef logic [`XPR_LEN/8-1:0] rv32_be_t;

    // ========================================
    // decoded instructions
    // ========================================

    // anything outside this list decodes to RV32_NOP
    typedef enum logic [5:0] {
        RV32_NOP,
        RV32_LUI, RV32_AUIPC, RV32_JAL, RV32_JALR,
        RV32_BEQ, RV32_BNE, RV32_BLT, RV32_BGE, RV32_BLTU, RV32_BGEU,
        RV32_LB, RV32_LH, RV32_LW, RV32_LBU, RV32_LHU,
        RV32_SB, RV32_SH, RV32_SW,
        RV32_ADDI, RV32_SLTI, RV32_SLTIU, RV32_XORI, RV32_ORI, RV32_ANDI,
        RV32_SLLI, RV32_SRLI, RV32_SRAI,
        RV32_ADD, RV32_SUB, RV32_SLL, RV32_SLT, RV32_SLTU,
        RV32_XOR, RV32_SRL, RV32_SRA, RV32_OR, RV32_AND
    } rv32_opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } rv32_alu_op_t;

endpackage

// File: src/rv32_decoder.sv
`timescale 1ns/10ps

module rv32_decoder (
    input  rv32_pkg::rv32_data_t     instr,
    output rv32_pkg::rv32_opcode_t   opcode,
    output rv32_pkg::rv32_reg_addr_t rd,
    output rv32_pkg::rv32_reg_addr_t rs1,
    output rv32_pkg::rv32_reg_addr_t rs2,
    output rv32_pkg::rv32_data_t     imm,
    output rv32_pkg::rv32_alu_op_t   alu_op
);
    import rv32_pkg::*;

    logic [2:0] funct3;
    logic       f7_zero;
    logic       f7_alt;
    rv32_data_t imm_i;
    rv32_data_t imm_s;
    rv32_data_t imm_b;
    rv32_data_t imm_u;
    rv32_data_t imm_j;
    rv32_data_t imm_sh;

    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct3 = instr[14:12];

    assign f7_zero = (instr[31:25] == 7'b0000000);
    assign f7_alt  = (instr[31:25] == 7'b0100000);

    // immediate formats, all sign extended from bit 31
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u  = {instr[31:12], 12'b0};
    assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_sh = {27'b0, instr[24:20]};

    always_comb begin
        opcode = RV32_NOP;
        imm    = imm_i;
        alu_op = ALU_ADD;
        case (instr[6:0])
            7'b0110111: begin
                opcode = RV32_LUI;
                imm    = imm_u;
            end
            7'b0010111: begin
                opcode = RV32_AUIPC;
                imm    = imm_u;
            end
            7'b1101111: begin
                opcode = RV32_JAL;
                imm    = imm_j;
            end
            7'b1100111: begin
                if (funct3 == 3'b000) begin
                    opcode = RV32_JALR;
                end
            end
            7'b1100011: begin
                imm = imm_b;
                case (funct3)
                    3'b000: opcode = RV32_BEQ;
                    3'b001: opcode = RV32_BNE;
                    3'b100: opcode = RV32_BLT;
                    3'b101: opcode = RV32_BGE;
                    3'b110: opcode = RV32_BLTU;
                    3'b111: opcode = RV32_BGEU;
                    default: opcode = RV32_NOP;
                endcase
            end
            7'b0000011: begin
                case (funct3)
                    3'b000: opcode = RV32_LB;
                    3'b001: opcode = RV32_LH;
                    3'b010: opcode = RV32_LW;
                    3'b100: opcode = RV32_LBU;
                    3'b101: opcode = RV32_LHU;
                    default: opcode = RV32_NOP;
                endcase
            end
            7'b0100011: begin
                imm = imm_s;
                case (funct3)
                    3'b000: opcode = RV32_SB;
                    3'b001: opcode = RV32_SH;
                    3'b010: opcode = RV32_SW;
                    default: opcode = RV32_NOP;
                endcase
            end
            // immediate ALU ops
            7'b0010011: begin
                case (funct3)
                    3'b000: opcode = RV32_ADDI;
                    3'b010: {opcode, alu_op} = {RV32_SLTI, ALU_SLT};
                    3'b011: {opcode, alu_op} = {RV32_SLTIU, ALU_SLTU};
                    3'b100: {opcode, alu_op} = {RV32_XORI, ALU_XOR};
                    3'b110: {opcode, alu_op} = {RV32_ORI, ALU_OR};
                    3'b111: {opcode, alu_op} = {RV32_ANDI, ALU_AND};
                    3'b001: begin
                        imm = imm_sh;
                        if (f7_zero) begin
                            {opcode, alu_op} = {RV32_SLLI, ALU_SLL};
                        end
                    end
                    default: begin
                        imm = imm_sh;
                        if (f7_zero) begin
                            {opcode, alu_op} = {RV32_SRLI, ALU_SRL};
                        end else if (f7_alt) begin
                            {opcode, alu_op} = {RV32_SRAI, ALU_SRA};
                        end
                    end
                endcase
            end
            // register ALU ops, only SUB and SRA use the alternate funct7
            7'b0110011: begin
                if (f7_zero || (f7_alt && ((funct3 == 3'b000) || (funct3 == 3'b101)))) begin
                    case (funct3)
                        3'b000: {opcode, alu_op} = f7_alt ? {RV32_SUB, ALU_SUB}
                                                          : {RV32_ADD, ALU_ADD};
                        3'b001: {opcode, alu_op} = {RV32_SLL, ALU_SLL};
                        3'b010: {opcode, alu_op} = {RV32_SLT, ALU_SLT};
                        3'b011: {opcode, alu_op} = {RV32_SLTU, ALU_SLTU};
                        3'b100: {opcode, alu_op} = {RV32_XOR, ALU_XOR};
                        3'b101: {opcode, alu_op} = f7_alt ? {RV32_SRA, ALU_SRA}
                                                          : {RV32_SRL, ALU_SRL};
                        3'b110: {opcode, alu_op} = {RV32_OR, ALU_OR};
                        default: {opcode, alu_op} = {RV32_AND, ALU_AND};
                    endcase
                end
            end
            default: opcode = RV32_NOP;
        endcase
    end

endmodule

// File: src/rv32_barrel_regfile.sv
`timescale 1ns/10ps
`include "rv32_defs.svh"

module rv32_barrel_regfile (
    input  logic                     clk,
    input  rv32_pkg::rv32_hart_t     rd_hart,
    input  rv32_pkg::rv32_reg_addr_t ra1,
    input  rv32_pkg::rv32_reg_addr_t ra2,
    output rv32_pkg::rv32_data_t     rd1,
    output rv32_pkg::rv32_data_t     rd2,
    input  logic                     wen,
    input  rv32_pkg::rv32_hart_t     wr_hart,
    input  rv32_pkg::rv32_reg_addr_t wa,
    input  rv32_pkg::rv32_data_t     wd
);
    import rv32_pkg::*;

    // one bank of 32 registers per hart
    rv32_data_t regs [0:`RV_NUM_HARTS-1][0:(1 << `REG_ADDR_W)-1];

    // x0 is hardwired to zero on the read side
    assign rd1 = (ra1 == '0) ? '0 : regs[rd_hart][ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[rd_hart][ra2];

    always_ff @(posedge clk) begin
        if (wen && (wa != '0)) begin
            regs[wr_hart][wa] <= wd;
        end
    end

endmodule

// File: src/rv32_execute.sv
`timescale 1ns/10ps
`include "rv32_defs.svh"

module rv32_execute (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid,
    input  rv32_pkg::rv32_opcode_t    opcode,
    input  rv32_pkg::rv32_alu_op_t    alu_op,
    input  rv32_pkg::rv32_data_t      pc,
    input  rv32_pkg::rv32_data_t      imm,
    input  rv32_pkg::rv32_data_t      op1,
    input  rv32_pkg::rv32_data_t      op2,
    output rv32_pkg::rv32_data_t      result,
    output logic                      redirect,
    output rv32_pkg::rv32_data_t      next_pc,
    output logic                      dmem_req,
    output logic                      dmem_we,
    output rv32_pkg::rv32_be_t        dmem_be,
    output rv32_pkg::rv32_dmem_addr_t dmem_addr,
    output rv32_pkg::rv32_data_t      dmem_wdata,
    output logic [1:0]                load_lane
);
    import rv32_pkg::*;

    logic       is_load;
    logic       is_store;
    logic       use_rs2;
    logic       taken;
    rv32_data_t alu_b;
    rv32_data_t alu_out;
    rv32_data_t st_data;
    rv32_be_t   st_be;

    assign is_load  = opcode inside {RV32_LB, RV32_LH, RV32_LW, RV32_LBU, RV32_LHU};
    assign is_store = opcode inside {RV32_SB, RV32_SH, RV32_SW};
    assign use_rs2  = opcode inside {RV32_ADD, RV32_SUB, RV32_SLL, RV32_SLT, RV32_SLTU,
                                     RV32_XOR, RV32_SRL, RV32_SRA, RV32_OR, RV32_AND};

    // ========================================
    // ALU
    // ========================================

    // loads, stores and JALR get op1 + imm from the default add
    assign alu_b = use_rs2 ? op2 : imm;

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_out = op1 - alu_b;
            ALU_SLL:  alu_out = op1 << alu_b[4:0];
            ALU_SLT:  alu_out = {{(`XPR_LEN-1){1'b0}}, $signed(op1) < $signed(alu_b)};
            ALU_SLTU: alu_out = {{(`XPR_LEN-1){1'b0}}, op1 < alu_b};
            ALU_XOR:  alu_out = op1 ^ alu_b;
            ALU_SRL:  alu_out = op1 >> alu_b[4:0];
            ALU_SRA:  alu_out = $signed(op1) >>> alu_b[4:0];
            ALU_OR:   alu_out = op1 | alu_b;
            ALU_AND:  alu_out = op1 & alu_b;
            default:  alu_out = op1 + alu_b;
        endcase
    end

    always_comb begin
        case (opcode)
            RV32_LUI:            result = imm;
            RV32_AUIPC:          result = pc + imm;
            RV32_JAL, RV32_JALR: result = pc + 32'd4;
            default:             result = alu_out;
        endcase
    end

    // ========================================
    // branch resolution
    // ========================================

    always_comb begin
        case (opcode)
            RV32_BEQ:            taken = (op1 == op2);
            RV32_BNE:            taken = (op1 != op2);
            RV32_BLT:            taken = ($signed(op1) < $signed(op2));
            RV32_BGE:            taken = ($signed(op1) >= $signed(op2));
            RV32_BLTU:           taken = (op1 < op2);
            RV32_BGEU:           taken = (op1 >= op2);
            RV32_JAL, RV32_JALR: taken = 1'b1;
            default:             taken = 1'b0;
        endcase
    end

    assign redirect = valid && taken;
    assign next_pc  = (opcode == RV32_JALR) ? {alu_out[31:1], 1'b0} : pc + imm;

    // ========================================
    // store lanes and memory request (stage M)
    // ========================================

    always_comb begin
        case (opcode)
            RV32_SB: begin
                st_be   = 4'b0001 << alu_out[1:0];
                st_data = {24'b0, op2[7:0]} << {alu_out[1:0], 3'b000};
            end
            RV32_SH: begin
                st_be   = alu_out[1] ? 4'b1100 : 4'b0011;
                st_data = alu_out[1] ? {op2[15:0], 16'b0} : {16'b0, op2[15:0]};
            end
            default: begin
                st_be   = 4'b1111;
                st_data = op2;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmem_req <= 1'b0;
            dmem_we  <= 1'b0;
        end else begin
            dmem_req <= valid && (is_load || is_store);
            dmem_we  <= valid && is_store;
        end
    end

    always_ff @(posedge clk) begin
        dmem_be    <= st_be;
        dmem_addr  <= alu_out[`DMEM_ADDR_W+1:2];
        dmem_wdata <= st_data;
        load_lane  <= alu_out[1:0];
    end

endmodule

// File: src/rv32_result.sv
`timescale 1ns/10ps

module rv32_result (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     valid,
    input  rv32_pkg::rv32_opcode_t   opcode,
    input  rv32_pkg::rv32_reg_addr_t rd,
    input  rv32_pkg::rv32_data_t     result,
    input  logic [1:0]               load_lane,
    input  rv32_pkg::rv32_data_t     dmem_rdata,
    output logic                     wen,
    output rv32_pkg::rv32_reg_addr_t wa,
    output rv32_pkg::rv32_data_t     wd
);
    import rv32_pkg::*;

    logic           w_valid;
    rv32_opcode_t   w_opcode;
    rv32_reg_addr_t w_rd;
    rv32_data_t     w_result;
    logic [1:0]     w_lane;
    logic [7:0]     ld_byte;
    logic [15:0]    ld_half;

    // M to W register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_valid <= 1'b0;
        end else begin
            w_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        w_opcode <= opcode;
        w_rd     <= rd;
        w_result <= result;
        w_lane   <= load_lane;
    end

    // ========================================
    // load lane extraction
    // ========================================

    assign ld_byte = dmem_rdata[{w_lane, 3'b000} +: 8];
    assign ld_half = w_lane[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

    always_comb begin
        case (w_opcode)
            RV32_LB:  wd = {{24{ld_byte[7]}}, ld_byte};
            RV32_LBU: wd = {24'b0, ld_byte};
            RV32_LH:  wd = {{16{ld_half[15]}}, ld_half};
            RV32_LHU: wd = {16'b0, ld_half};
            RV32_LW:  wd = dmem_rdata;
            default:  wd = w_result;
        endcase
    end

    // branches, stores and no-ops leave the bank alone
    assign wen = w_valid && !(w_opcode inside {RV32_BEQ, RV32_BNE, RV32_BLT, RV32_BGE,
                                               RV32_BLTU, RV32_BGEU, RV32_SB, RV32_SH,
                                               RV32_SW, RV32_NOP});
    assign wa  = w_rd;

endmodule

// File: src/rv32_core.sv
`timescale 1ns/10ps
`include "rv32_defs.svh"

module rv32_core (
    input  logic                      clk,
    input  logic                      rst_n,
    output rv32_pkg::rv32_imem_addr_t imem_addr,
    output logic                      imem_req,
    input  rv32_pkg::rv32_data_t      imem_rdata,
    output logic                      dmem_req,
    output logic                      dmem_we,
    output rv32_pkg::rv32_be_t        dmem_be,
    output rv32_pkg::rv32_dmem_addr_t dmem_addr,
    output rv32_pkg::rv32_data_t      dmem_wdata,
    input  rv32_pkg::rv32_data_t      dmem_rdata
);
    import rv32_pkg::*;

    // hart scheduling
    rv32_hart_t     hart_cnt;
    rv32_data_t     pc [0:`RV_NUM_HARTS-1];

    // fetch register
    logic           f_valid;
    rv32_hart_t     f_hart;
    rv32_data_t     f_pc;

    // decode outputs
    rv32_opcode_t   d_opcode;
    rv32_alu_op_t   d_alu_op;
    rv32_reg_addr_t d_rd;
    rv32_reg_addr_t d_rs1;
    rv32_reg_addr_t d_rs2;
    rv32_data_t     d_imm;
    rv32_data_t     d_rd1;
    rv32_data_t     d_rd2;

    // D to E register
    logic           e_valid;
    rv32_hart_t     e_hart;
    rv32_opcode_t   e_opcode;
    rv32_alu_op_t   e_alu_op;
    rv32_reg_addr_t e_rd;
    rv32_data_t     e_pc;
    rv32_data_t     e_imm;
    rv32_data_t     e_op1;
    rv32_data_t     e_op2;

    // execute outputs
    rv32_data_t     x_result;
    rv32_data_t     x_next_pc;
    logic           x_redirect;
    logic [1:0]     m_lane;

    // E to M register and write-back tags
    logic           m_valid;
    rv32_hart_t     m_hart;
    rv32_opcode_t   m_opcode;
    rv32_reg_addr_t m_rd;
    rv32_data_t     m_result;
    rv32_hart_t     w_hart;
    logic           wb_wen;
    rv32_reg_addr_t wb_wa;
    rv32_data_t     wb_wd;

    // ========================================
    // hart counter, PCs and fetch (stage F)
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hart_cnt <= '0;
            for (int i = 0; i < `RV_NUM_HARTS; i++) begin
                pc[i] <= `RESET_ADDRESS;
            end
        end else begin
            hart_cnt     <= (hart_cnt == `HART_W'(`RV_NUM_HARTS - 1)) ? '0 : hart_cnt + 1'b1;
            pc[hart_cnt] <= pc[hart_cnt] + 32'd4;
            // the hart in E is never the one fetching, so both writes can land
            if (x_redirect) begin
                pc[e_hart] <= x_next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            f_valid <= 1'b0;
            f_hart  <= '0;
            f_pc    <= `RESET_ADDRESS;
        end else begin
            f_valid <= 1'b1;
            f_hart  <= hart_cnt;
            f_pc    <= pc[hart_cnt];
        end
    end

    assign imem_req  = f_valid;
    assign imem_addr = f_pc[`IMEM_ADDR_W+1:2];

    // ========================================
    // decode and register read (stage D)
    // ========================================

    rv32_decoder i_decoder (
        .instr  (imem_rdata),
        .opcode (d_opcode  ),
        .rd     (d_rd      ),
        .rs1    (d_rs1     ),
        .rs2    (d_rs2     ),
        .imm    (d_imm     ),
        .alu_op (d_alu_op  )
    );

    rv32_barrel_regfile i_regfile (
        .clk     (clk   ),
        .rd_hart (f_hart),
        .ra1     (d_rs1 ),
        .ra2     (d_rs2 ),
        .rd1     (d_rd1 ),
        .rd2     (d_rd2 ),
        .wen     (wb_wen),
        .wr_hart (w_hart),
        .wa      (wb_wa ),
        .wd      (wb_wd )
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid <= 1'b0;
            m_valid <= 1'b0;
        end else begin
            e_valid <= f_valid;
            m_valid <= e_valid;
        end
    end

    always_ff @(posedge clk) begin
        e_hart   <= f_hart;
        e_opcode <= d_opcode;
        e_alu_op <= d_alu_op;
        e_rd     <= d_rd;
        e_pc     <= f_pc;
        e_imm    <= d_imm;
        e_op1    <= d_rd1;
        e_op2    <= d_rd2;
        // carried through M into W
        m_hart   <= e_hart;
        m_opcode <= e_opcode;
        m_rd     <= e_rd;
        m_result <= x_result;
        w_hart   <= m_hart;
    end

    // ========================================
    // execute (E), memory (M), write-back (W)
    // ========================================

    rv32_execute i_execute (
        .clk        (clk       ),
        .rst_n      (rst_n     ),
        .valid      (e_valid   ),
        .opcode     (e_opcode  ),
        .alu_op     (e_alu_op  ),
        .pc         (e_pc      ),
        .imm        (e_imm     ),
        .op1        (e_op1     ),
        .op2        (e_op2     ),
        .result     (x_result  ),
        .redirect   (x_redirect),
        .next_pc    (x_next_pc ),
        .dmem_req   (dmem_req  ),
        .dmem_we    (dmem_we   ),
        .dmem_be    (dmem_be   ),
        .dmem_addr  (dmem_addr ),
        .dmem_wdata (dmem_wdata),
        .load_lane  (m_lane    )
    );

    rv32_result i_result (
        .clk        (clk       ),
        .rst_n      (rst_n     ),
        .valid      (m_valid   ),
        .opcode     (m_opcode  ),
        .rd         (m_rd      ),
        .result     (m_result  ),
        .load_lane  (m_lane    ),
        .dmem_rdata (dmem_rdata),
        .wen        (wb_wen    ),
        .wa         (wb_wa     ),
        .wd         (wb_wd     )
    );

endmodule

// File: verification/tb_rv32_core.sv
`timescale 1ns/10ps
`include "rv32_defs.svh"

module tb_rv32_core;
    import rv32_pkg::*;

    localparam int TIMEOUT    = 200;
    localparam int TABLE_SIZE = 64;
    localparam int IMEM_WORDS = 1 << `IMEM_ADDR_W;
    localparam int DMEM_WORDS = 1 << `DMEM_ADDR_W;

    logic            clk = 1'b0;
    logic            rst_n;
    rv32_imem_addr_t imem_addr;
    logic            imem_req;
    rv32_data_t      imem_rdata;
    logic            dmem_req;
    logic            dmem_we;
    rv32_be_t        dmem_be;
    rv32_dmem_addr_t dmem_addr;
    rv32_data_t      dmem_wdata;
    rv32_data_t      dmem_rdata;

    rv32_data_t      imem [0:IMEM_WORDS-1];
    rv32_data_t      dmem [0:DMEM_WORDS-1];
    rv32_data_t      dmem_init [0:DMEM_WORDS-1];
    logic            rd_pend;
    rv32_dmem_addr_t rd_addr;
    int              seed = 35;
    int              cycle_cnt = 0;

    // expected store table
    rv32_dmem_addr_t exp_addr [0:TABLE_SIZE-1];
    rv32_data_t      exp_data [0:TABLE_SIZE-1];
    rv32_be_t        exp_be [0:TABLE_SIZE-1];
    int              n_exp;
    int              n_instr;
    int              st_off;

    rv32_core i_dut (
        .clk        (clk       ),
        .rst_n      (rst_n     ),
        .imem_addr  (imem_addr ),
        .imem_req   (imem_req  ),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req  ),
        .dmem_we    (dmem_we   ),
        .dmem_be    (dmem_be   ),
        .dmem_addr  (dmem_addr ),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ========================================
    // memory models
    // ========================================

    assign imem_rdata = imem[imem_addr];

    // read data of last cycle's request is driven here and held for a full cycle
    always @(negedge clk) begin
        if (rd_pend) begin
            dmem_rdata = dmem[rd_addr];
        end
        rd_pend = dmem_req && !dmem_we;
        rd_addr = dmem_addr;
        if (dmem_req && dmem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_be[b]) begin
                    dmem[dmem_addr][8*b +: 8] = dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    // ========================================
    // instruction encoding
    // ========================================

    function automatic rv32_data_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv32_data_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv32_data_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv32_data_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv32_data_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // ========================================
    // program and expectation table
    // ========================================

    task automatic add_instr(input rv32_data_t instr);
        imem[n_instr] = instr;
        n_instr++;
    endtask

    task automatic add_store(input logic [2:0] f3, input logic [4:0] rs2, input int off,
                             input rv32_data_t data, input rv32_be_t be);
        add_instr(enc_s(12'(off), rs2, 5'd10, f3));
        exp_addr[n_exp] = rv32_dmem_addr_t'((32'h400 + off) >> 2);
        exp_data[n_exp] = data;
        exp_be[n_exp]   = be;
        n_exp++;
    endtask

    task automatic add_sw(input logic [4:0] rs2, input rv32_data_t data);
        add_store(3'b010, rs2, st_off, data, 4'b1111);
        st_off += 4;
    endtask

    task automatic build_program();
        rv32_data_t wrd;
        logic [7:0] b;
        logic [15:0] h;
        int jal_pc;
        wrd = dmem_init[32'h200 >> 2];
        n_instr = 0;
        n_exp = 0;
        st_off = 0;
        add_instr(enc_i(12'h400, 5'd0, 3'b000, 5'd10, 7'b0010011));
        add_instr(enc_i(12'h200, 5'd0, 3'b000, 5'd11, 7'b0010011));
        add_instr({20'h80000, 5'd1, 7'b0110111});
        add_instr(enc_i(12'hfff, 5'd0, 3'b000, 5'd2, 7'b0010011));
        add_instr(enc_i(12'd5, 5'd0, 3'b000, 5'd3, 7'b0010011));
        // x1 = 0x80000000, x2 = -1, x3 = 5
        add_instr(enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
        add_sw(5'd4, 32'd6);
        add_instr(enc_r(7'h20, 5'd3, 5'd1, 3'b101, 5'd5));
        add_sw(5'd5, 32'hfc00_0000);
        add_instr(enc_r(7'h00, 5'd3, 5'd1, 3'b010, 5'd6));
        add_sw(5'd6, 32'd1);
        add_instr(enc_r(7'h00, 5'd3, 5'd1, 3'b011, 5'd7));
        add_sw(5'd7, 32'd0);
        add_instr(enc_i(12'h555, 5'd2, 3'b100, 5'd8, 7'b0010011));
        add_sw(5'd8, 32'hffff_faaa);
        add_instr(enc_i(12'h404, 5'd1, 3'b101, 5'd9, 7'b0010011));
        add_sw(5'd9, 32'hf800_0000);
        add_instr(enc_i(12'hfff, 5'd3, 3'b011, 5'd12, 7'b0010011));
        add_sw(5'd12, 32'd1);
        add_instr(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd12));
        add_sw(5'd12, 32'h7fff_ffff);
        // byte loads from every lane of the preset word
        for (int lane = 0; lane < 4; lane++) begin
            b = wrd[8*lane +: 8];
            add_instr(enc_i(12'(lane), 5'd11, 3'b000, 5'd13, 7'b0000011));
            add_sw(5'd13, {{24{b[7]}}, b});
            add_instr(enc_i(12'(lane), 5'd11, 3'b100, 5'd14, 7'b0000011));
            add_sw(5'd14, {24'b0, b});
        end
        for (int lane = 0; lane < 4; lane += 2) begin
            h = wrd[8*lane +: 16];
            add_instr(enc_i(12'(lane), 5'd11, 3'b001, 5'd15, 7'b0000011));
            add_sw(5'd15, {{16{h[15]}}, h});
            add_instr(enc_i(12'(lane), 5'd11, 3'b101, 5'd16, 7'b0000011));
            add_sw(5'd16, {16'b0, h});
        end
        // sub-word stores of 0x12345678
        add_instr({20'h12345, 5'd18, 7'b0110111});
        add_instr(enc_i(12'h678, 5'd18, 3'b000, 5'd18, 7'b0010011));
        add_store(3'b000, 5'd18, st_off, 32'h0000_0078, 4'b0001);
        add_store(3'b000, 5'd18, st_off + 1, 32'h0000_7800, 4'b0010);
        add_store(3'b000, 5'd18, st_off + 2, 32'h0078_0000, 4'b0100);
        add_store(3'b000, 5'd18, st_off + 3, 32'h7800_0000, 4'b1000);
        st_off += 4;
        add_store(3'b001, 5'd18, st_off, 32'h0000_5678, 4'b0011);
        add_store(3'b001, 5'd18, st_off + 2, 32'h5678_0000, 4'b1100);
        st_off += 4;
        // taken branch skips a stray store, not-taken one falls through
        add_instr(enc_b(13'd8, 5'd3, 5'd3, 3'b000));
        add_instr(enc_s(12'h7f0, 5'd0, 5'd10, 3'b010));
        add_instr(enc_b(13'd8, 5'd3, 5'd3, 3'b001));
        add_sw(5'd3, 32'd5);
        jal_pc = 4 * n_instr;
        add_instr(enc_j(21'd8, 5'd19));
        add_instr(enc_s(12'h7f4, 5'd0, 5'd10, 3'b010));
        add_sw(5'd19, 32'(jal_pc + 4));
        add_instr(enc_j(21'd0, 5'd0));
        // only reached if the final loop falls through
        add_instr(enc_s(12'h7f8, 5'd0, 5'd10, 3'b010));
    endtask

    // ========================================
    // checks
    // ========================================

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "testbench stopped");
    endtask

    task automatic value_error(input string msg);
        fail_now($sformatf("FAILED at %0t: %s", $time, msg));
    endtask

    task automatic check_store(input rv32_dmem_addr_t addr, input rv32_data_t data,
                               input rv32_be_t be, input int idx);
        if (dmem_addr !== addr || dmem_wdata !== data || dmem_be !== be) begin
            value_error($sformatf("store %0d got addr %0h data %h be %b, expected %0h %h %b",
                                  idx, dmem_addr, dmem_wdata, dmem_be, addr, data, be));
        end
    endtask

    task automatic check_fetch(input rv32_imem_addr_t addr);
        if (imem_addr !== addr) begin
            value_error($sformatf("fetch address %0h, expected %0h", imem_addr, addr));
        end
    endtask

    task automatic wait_store(output int cyc);
        int n;
        n = 0;
        @(negedge clk);
        while (!(dmem_req === 1'b1 && dmem_we === 1'b1)) begin
            n++;
            if (n > TIMEOUT) begin
                fail_now($sformatf("no data memory write arrived within %0d cycles", TIMEOUT));
            end
            @(negedge clk);
        end
        cyc = cycle_cnt;
    endtask

    // ========================================
    // main sequence
    // ========================================

    initial begin
        int n;
        int cyc;
        int last_cyc;
        rst_n      = 1'b0;
        dmem_rdata = '0;
        rd_pend    = 1'b0;
        rd_addr    = '0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]      = $random(seed);
            dmem_init[i] = dmem[i];
        end
        // load word with positive and negative bytes and halves
        dmem[32'h200 >> 2]      = 32'h807f_01ff;
        dmem_init[32'h200 >> 2] = dmem[32'h200 >> 2];
        build_program();

        repeat (3) @(negedge clk);
        if (imem_req !== 1'b0 || dmem_req !== 1'b0 || dmem_we !== 1'b0) begin
            value_error("memory request active during reset");
        end
        rst_n = 1'b1;

        n = 0;
        @(negedge clk);
        while (imem_req !== 1'b1) begin
            n++;
            if (n > TIMEOUT) begin
                fail_now("instruction fetch never started after reset");
            end
            @(negedge clk);
        end
        check_fetch(rv32_imem_addr_t'(`RESET_ADDRESS >> 2));

        // each entry once per hart, harts on consecutive cycles
        last_cyc = 0;
        for (int e = 0; e < n_exp; e++) begin
            for (int hart = 0; hart < `RV_NUM_HARTS; hart++) begin
                wait_store(cyc);
                check_store(exp_addr[e], exp_data[e], exp_be[e], e);
                if (hart > 0 && cyc != last_cyc + 1) begin
                    value_error($sformatf("store %0d of hart %0d out of round-robin order",
                                          e, hart));
                end
                last_cyc = cyc;
            end
        end

        // the JAL loop must stay quiet
        repeat (64) begin
            @(negedge clk);
            if (dmem_we === 1'b1) begin
                value_error("unexpected data memory write after the program ended");
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: all.f
+incdir+src
src/rv32_pkg.sv
src/rv32_decoder.sv
src/rv32_barrel_regfile.sv
src/rv32_execute.sv
src/rv32_result.sv
src/rv32_core.sv
verification/tb_rv32_core.sv

// File: Makefile
TOP = tb_rv32_core

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir -o sim
	-./obj_dir/sim > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then echo "test FAILED"; exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
